// ==== logic/iq_capture_settings.svh ====
`ifndef IQ_CAPTURE_SETTINGS_SVH
`define IQ_CAPTURE_SETTINGS_SVH

// fifo pointer width, 16 entries of which 15 usable
`define IQ_ADDR_WIDTH 4

// one I or Q part
`define IQ_DATA_WIDTH 16

// APB register byte offsets
`define IQ_REG_SAMPLE 32'h0000_0000
`define IQ_REG_POWER  32'h0000_0004
`define IQ_REG_STATUS 32'h0000_0008
`define IQ_REG_CTRL   32'h0000_000C

// control register fields
`define IQ_CTRL_CONJ_BIT 0

`endif

// ==== logic/iq_capture_pkg.sv ====
`default_nettype none

`include "iq_capture_settings.svh"

package iq_capture_pkg;

	// complex sample, i in the upper half
	typedef struct packed {
		logic signed [`IQ_DATA_WIDTH-1:0] i;
		logic signed [`IQ_DATA_WIDTH-1:0] q;
	} iq_sample_t;

	typedef enum logic [2:0] {
		OP_RD_SAMPLE,
		OP_RD_POWER,
		OP_RD_STATUS,
		OP_WR_CTRL,
		OP_BAD
	} reg_op_e;

	// decoded APB access
	typedef struct packed {
		reg_op_e     op;
		logic [31:0] wdata;
	} op_req_t;

	// result back to the bus
	typedef struct packed {
		logic [31:0] rdata;
		logic        err;
	} op_res_t;

endpackage

`default_nettype wire

// ==== logic/iq_async_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "iq_capture_settings.svh"

module iq_async_fifo (
	input  logic                       wr_clk_i,
	input  logic                       wr_rst_b_i,
	input  logic                       wr_en_i,
	input  iq_capture_pkg::iq_sample_t wr_data_i,
	output logic                       full_o,

	input  logic                       rd_clk_i,
	input  logic                       rd_rst_b_i,
	input  logic                       rd_en_i,
	output iq_capture_pkg::iq_sample_t rd_data_o,
	output logic                       empty_o
);

	localparam int AW    = `IQ_ADDR_WIDTH;
	localparam int DW    = `IQ_DATA_WIDTH;
	localparam int DEPTH = 1 << AW;

	logic [DW-1:0] mem_i [DEPTH];
	logic [DW-1:0] mem_q [DEPTH];

	logic [AW-1:0] wr_addr, wr_addr_gray;
	logic [AW-1:0] rd_addr, rd_addr_gray;
	logic [AW-1:0] wr_gray_sync0, wr_gray_sync1; // write pointer in read domain
	logic [AW-1:0] rd_gray_sync0, rd_gray_sync1; // read pointer in write domain
	logic [AW-1:0] wr_next, wr_next2, rd_next;
	logic          wr_go, rd_go;

	function automatic logic [AW-1:0] gray_conv(input logic [AW-1:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	assign wr_go    = wr_en_i & ~full_o;  // drop while full
	assign rd_go    = rd_en_i & ~empty_o;
	assign wr_next  = wr_addr + 1'b1;
	assign wr_next2 = wr_addr + 2'd2;
	assign rd_next  = rd_addr + 1'b1;

	// write domain
	always_ff @(posedge wr_clk_i) begin
		if (!wr_rst_b_i) begin
			wr_addr       <= '0;
			wr_addr_gray  <= '0;
			rd_gray_sync0 <= '0;
			rd_gray_sync1 <= '0;
			full_o        <= 1'b0;
		end else begin
			rd_gray_sync0 <= rd_addr_gray;
			rd_gray_sync1 <= rd_gray_sync0;
			if (wr_go) begin
				wr_addr      <= wr_next;
				wr_addr_gray <= gray_conv(wr_next);
				full_o       <= gray_conv(wr_next2) == rd_gray_sync1;
			end else begin
				full_o <= full_o & (gray_conv(wr_next) == rd_gray_sync1);
			end
		end
	end

	always_ff @(posedge wr_clk_i) begin
		if (wr_go) begin
			mem_i[wr_addr] <= wr_data_i.i;
			mem_q[wr_addr] <= wr_data_i.q;
		end
	end

	// read domain
	always_ff @(posedge rd_clk_i) begin
		if (!rd_rst_b_i) begin
			rd_addr       <= '0;
			rd_addr_gray  <= '0;
			wr_gray_sync0 <= '0;
			wr_gray_sync1 <= '0;
			empty_o       <= 1'b1;
		end else begin
			wr_gray_sync0 <= wr_addr_gray;
			wr_gray_sync1 <= wr_gray_sync0;
			if (rd_go) begin
				rd_addr      <= rd_next;
				rd_addr_gray <= gray_conv(rd_next);
				empty_o      <= gray_conv(rd_next) == wr_gray_sync1;
			end else begin
				// falls once the synced write pointer moves on
				empty_o <= empty_o & (gray_conv(rd_addr) == wr_gray_sync1);
			end
		end
	end

	always_ff @(posedge rd_clk_i) begin
		if (rd_go) begin
			rd_data_o.i <= mem_i[rd_addr];
			rd_data_o.q <= mem_q[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/apb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "iq_capture_settings.svh"

module apb_decode (
	input  logic                    rd_clk_i,
	input  logic                    rd_rst_b_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [31:0]             paddr_i,
	input  logic [31:0]             pwdata_i,
	input  logic                    pready_i,
	output logic                    op_valid_o,
	output iq_capture_pkg::op_req_t op_req_o
);

	logic                    busy;
	logic                    start;
	iq_capture_pkg::reg_op_e op_d;

	// first access-phase cycle only
	assign start = psel_i & penable_i & ~busy;

	always_comb begin
		case (paddr_i)
			`IQ_REG_SAMPLE: op_d = pwrite_i ? iq_capture_pkg::OP_BAD : iq_capture_pkg::OP_RD_SAMPLE;
			`IQ_REG_POWER:  op_d = pwrite_i ? iq_capture_pkg::OP_BAD : iq_capture_pkg::OP_RD_POWER;
			`IQ_REG_STATUS: op_d = pwrite_i ? iq_capture_pkg::OP_BAD : iq_capture_pkg::OP_RD_STATUS;
			`IQ_REG_CTRL:   op_d = pwrite_i ? iq_capture_pkg::OP_WR_CTRL : iq_capture_pkg::OP_BAD;
			default:        op_d = iq_capture_pkg::OP_BAD;
		endcase
	end

	always_ff @(posedge rd_clk_i) begin
		if (!rd_rst_b_i) begin
			busy       <= 1'b0;
			op_valid_o <= 1'b0;
		end else begin
			op_valid_o <= start;
			if (start)
				busy <= 1'b1;
			else if (pready_i)
				busy <= 1'b0; // transfer done
		end
	end

	always_ff @(posedge rd_clk_i) begin
		if (start) begin
			op_req_o.op    <= op_d;
			op_req_o.wdata <= pwdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sample_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "iq_capture_settings.svh"

module sample_execute (
	input  logic                       rd_clk_i,
	input  logic                       rd_rst_b_i,
	input  logic                       op_valid_i,
	input  iq_capture_pkg::op_req_t    op_req_i,
	input  iq_capture_pkg::iq_sample_t fifo_data_i,
	input  logic                       fifo_empty_i,
	output logic                       fifo_rd_en_o,
	output logic                       res_valid_o,
	output iq_capture_pkg::op_res_t    res_o
);

	logic                       ctrl_conj;
	logic [15:0]                pop_cnt;
	iq_capture_pkg::iq_sample_t last_sample;

	logic                       s1_valid, s1_pop, s1_conj_wr;
	iq_capture_pkg::reg_op_e    s1_op;
	logic signed [31:0]         pow_i, pow_q;
	iq_capture_pkg::op_res_t    res_d;

	assign fifo_rd_en_o = op_valid_i & (op_req_i.op == iq_capture_pkg::OP_RD_SAMPLE)
		& ~fifo_empty_i;

	// power of last pop, before conjugation
	assign pow_i = last_sample.i * last_sample.i;
	assign pow_q = last_sample.q * last_sample.q;

	always_comb begin
		res_d.rdata = '0;
		res_d.err   = 1'b0;
		case (s1_op)
			iq_capture_pkg::OP_RD_SAMPLE: begin
				if (s1_pop) begin
					res_d.rdata[31:16] = fifo_data_i.i;
					res_d.rdata[15:0]  = ctrl_conj ? -fifo_data_i.q : fifo_data_i.q;
				end else begin
					res_d.err = 1'b1; // fifo was empty
				end
			end
			iq_capture_pkg::OP_RD_POWER:  res_d.rdata = $unsigned(pow_i) + $unsigned(pow_q);
			iq_capture_pkg::OP_RD_STATUS: res_d.rdata = {pop_cnt, 15'd0, fifo_empty_i};
			iq_capture_pkg::OP_WR_CTRL:   res_d.err = 1'b0;
			default:                      res_d.err = 1'b1;
		endcase
	end

	always_ff @(posedge rd_clk_i) begin
		if (!rd_rst_b_i) begin
			s1_valid    <= 1'b0;
			res_valid_o <= 1'b0;
			ctrl_conj   <= 1'b0;
			pop_cnt     <= '0;
		end else begin
			s1_valid    <= op_valid_i;
			res_valid_o <= s1_valid;
			if (fifo_rd_en_o)
				pop_cnt <= pop_cnt + 1'b1;
			if (s1_valid && s1_op == iq_capture_pkg::OP_WR_CTRL)
				ctrl_conj <= s1_conj_wr;
		end
	end

	always_ff @(posedge rd_clk_i) begin
		s1_op      <= op_req_i.op;
		s1_pop     <= fifo_rd_en_o;
		s1_conj_wr <= op_req_i.wdata[`IQ_CTRL_CONJ_BIT];
		if (s1_valid && s1_pop)
			last_sample <= fifo_data_i;
		if (s1_valid)
			res_o <= res_d;
	end

endmodule

`default_nettype wire

// ==== logic/apb_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_result (
	input  logic                    rd_clk_i,
	input  logic                    rd_rst_b_i,
	input  logic                    res_valid_i,
	input  iq_capture_pkg::op_res_t res_i,
	output logic [31:0]             prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o
);

	// handshake outputs, high for one cycle only
	always_ff @(posedge rd_clk_i) begin
		if (!rd_rst_b_i) begin
			pready_o  <= 1'b0;
			pslverr_o <= 1'b0;
		end else if (res_valid_i) begin
			pready_o  <= 1'b1;
			pslverr_o <= res_i.err;
		end else begin
			pready_o  <= 1'b0;
			pslverr_o <= 1'b0;
		end
	end

	// read data, only meaningful with pready
	always_ff @(posedge rd_clk_i) begin
		if (res_valid_i)
			prdata_o <= res_i.rdata;
	end

endmodule

`default_nettype wire

// ==== logic/iq_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_capture_top (
	input  logic                       wr_clk_i,
	input  logic                       wr_rst_b_i,
	input  logic                       sample_valid_i,
	input  iq_capture_pkg::iq_sample_t sample_i,
	output logic                       full_o,

	input  logic                       rd_clk_i,
	input  logic                       rd_rst_b_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [31:0]                paddr_i,
	input  logic [31:0]                pwdata_i,
	output logic [31:0]                prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o
);

	logic                       op_valid;
	iq_capture_pkg::op_req_t    op_req;
	logic                       fifo_rd_en;
	iq_capture_pkg::iq_sample_t fifo_data;
	logic                       fifo_empty;
	logic                       res_valid;
	iq_capture_pkg::op_res_t    res;

	iq_async_fifo fifo_i (
		.wr_clk_i   (wr_clk_i),
		.wr_rst_b_i (wr_rst_b_i),
		.wr_en_i    (sample_valid_i),
		.wr_data_i  (sample_i),
		.full_o     (full_o),
		.rd_clk_i   (rd_clk_i),
		.rd_rst_b_i (rd_rst_b_i),
		.rd_en_i    (fifo_rd_en),
		.rd_data_o  (fifo_data),
		.empty_o    (fifo_empty)
	);

	apb_decode decode_i (
		.rd_clk_i   (rd_clk_i),
		.rd_rst_b_i (rd_rst_b_i),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.pready_i   (pready_o),
		.op_valid_o (op_valid),
		.op_req_o   (op_req)
	);

	sample_execute execute_i (
		.rd_clk_i     (rd_clk_i),
		.rd_rst_b_i   (rd_rst_b_i),
		.op_valid_i   (op_valid),
		.op_req_i     (op_req),
		.fifo_data_i  (fifo_data),
		.fifo_empty_i (fifo_empty),
		.fifo_rd_en_o (fifo_rd_en),
		.res_valid_o  (res_valid),
		.res_o        (res)
	);

	apb_result result_i (
		.rd_clk_i    (rd_clk_i),
		.rd_rst_b_i  (rd_rst_b_i),
		.res_valid_i (res_valid),
		.res_i       (res),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o)
	);

endmodule

`default_nettype wire

// ==== tests/iq_capture_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "iq_capture_settings.svh"

module iq_capture_tb;

	localparam int CYCLE_LIMIT = 2000; // ~60 transfers of 6 cycles plus fill waits

	logic wr_clk, wr_rst_b, sample_valid, full;
	logic rd_clk, rd_rst_b, psel, penable, pwrite, pready, pslverr;
	logic [31:0] paddr, pwdata, prdata;
	iq_capture_pkg::iq_sample_t sample;
	iq_capture_pkg::iq_sample_t model_q[$];
	iq_capture_pkg::iq_sample_t popped;
	integer seed;
	int errors, checks, tests, pops, cycles;
	logic conj_exp, full_seen;

	iq_capture_top dut_i (
		.wr_clk_i(wr_clk), .wr_rst_b_i(wr_rst_b), .sample_valid_i(sample_valid),
		.sample_i(sample), .full_o(full),
		.rd_clk_i(rd_clk), .rd_rst_b_i(rd_rst_b), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata),
		.prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
	);

	initial begin
		rd_clk = 1'b0;
		forever #20 rd_clk = ~rd_clk;
	end

	initial begin
		wr_clk = 1'b0;
		forever #14 wr_clk = ~wr_clk;
	end

	// pready is a one-cycle pulse
	assert property (@(posedge rd_clk) disable iff (!rd_rst_b) pready |=> !pready)
	else begin
		$display("ERROR %0t: pready held for more than one cycle", $time);
		errors++;
	end

	assert property (@(posedge rd_clk) disable iff (!rd_rst_b)
		(psel && penable && !$past(penable)) |-> !pready [*4] ##1 pready)
	else begin
		$display("ERROR %0t: access phase not five cycles long", $time);
		errors++;
	end

	always @(negedge wr_clk)
		if (full)
			full_seen <= 1'b1;

	function automatic logic [31:0] sample_word(input iq_capture_pkg::iq_sample_t s,
		input logic conj);
		logic [15:0] qv;
		qv = s.q;
		if (conj)
			qv = ~qv + 1'b1; // two's complement negate
		return {s.i, qv};
	endfunction

	function automatic logic [31:0] power_of(input iq_capture_pkg::iq_sample_t s);
		int ii, qq;
		ii = s.i;
		qq = s.q;
		return ii * ii + qq * qq;
	endfunction

	task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp_data,
		input logic exp_err, input logic chk_data, input string what);
		@(posedge rd_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge rd_clk);
		penable <= 1'b1;
		do @(negedge rd_clk); while (!pready);
		checks++;
		assert (pslverr == exp_err && (!chk_data || prdata == exp_data))
		else begin
			$display("ERROR %0t: %s got data %h err %b, expected %h err %b",
				$time, what, prdata, pslverr, exp_data, exp_err);
			errors++;
		end
		@(posedge rd_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
		input logic exp_err, input string what);
		@(posedge rd_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge rd_clk);
		penable <= 1'b1;
		do @(negedge rd_clk); while (!pready);
		checks++;
		assert (pslverr == exp_err)
		else begin
			$display("ERROR %0t: %s got err %b, expected %b", $time, what, pslverr, exp_err);
			errors++;
		end
		@(posedge rd_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	// back to back writes, only the first keep of them fit
	task automatic push_samples(input int n, input int keep);
		iq_capture_pkg::iq_sample_t s;
		for (int k = 0; k < n; k++) begin
			s = $random(seed);
			@(posedge wr_clk);
			sample_valid <= 1'b1;
			sample       <= s;
			if (k < keep)
				model_q.push_back(s);
		end
		@(posedge wr_clk);
		sample_valid <= 1'b0;
		do @(negedge rd_clk); while (dut_i.fifo_empty); // crossing latency varies
	endtask

	task automatic pop_and_check(input logic with_power);
		popped = model_q.pop_front();
		apb_read(`IQ_REG_SAMPLE, sample_word(popped, conj_exp), 1'b0, 1'b1, "SAMPLE");
		pops++;
		if (with_power)
			apb_read(`IQ_REG_POWER, power_of(popped), 1'b0, 1'b1, "POWER");
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("test %0d %s: pass", tests, name);
		else
			$display("test %0d %s: fail, %0d errors", tests, name, errors - errs_before);
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge rd_clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d rd_clk cycles", cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		wr_rst_b = 1'b0;
		repeat (4) @(posedge wr_clk);
		wr_rst_b <= 1'b1;
	end

	initial begin
		int e;
		seed = 32'h5ab0f255;
		rd_rst_b = 1'b0;
		sample_valid = 1'b0;
		sample = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		pops = 0;
		conj_exp = 1'b0;
		full_seen = 1'b0;
		repeat (4) @(posedge rd_clk);
		rd_rst_b <= 1'b1;
		repeat (2) @(posedge rd_clk);

		e = errors;
		push_samples(8, 8);
		repeat (8) pop_and_check(1'b1);
		finish_test("in-order reads with power", e);

		e = errors;
		push_samples(2, 2);
		apb_write(`IQ_REG_CTRL, 32'd1, 1'b0, "CTRL write");
		conj_exp = 1'b1;
		repeat (2) pop_and_check(1'b1);
		apb_write(`IQ_REG_CTRL, 32'd0, 1'b0, "CTRL write");
		conj_exp = 1'b0;
		finish_test("conjugation", e);

		e = errors;
		apb_read(`IQ_REG_SAMPLE, 32'd0, 1'b1, 1'b1, "empty SAMPLE");
		apb_read(`IQ_REG_STATUS, {pops[15:0], 15'd0, 1'b1}, 1'b0, 1'b1, "STATUS");
		finish_test("empty reads", e);

		e = errors;
		full_seen = 1'b0;
		push_samples(20, 15);
		checks++;
		assert (full_seen)
		else begin
			$display("ERROR %0t: full_o never rose during overflow", $time);
			errors++;
		end
		repeat (15) pop_and_check(1'b0);
		apb_read(`IQ_REG_SAMPLE, 32'd0, 1'b1, 1'b1, "SAMPLE after overflow");
		finish_test("overflow", e);

		e = errors;
		push_samples(1, 1);
		apb_read(32'h10, 32'd0, 1'b1, 1'b0, "unmapped read");
		apb_read(`IQ_REG_CTRL, 32'd0, 1'b1, 1'b0, "CTRL read");
		apb_write(`IQ_REG_SAMPLE, 32'hdead_beef, 1'b1, "SAMPLE write");
		apb_read(`IQ_REG_STATUS, {pops[15:0], 15'd0, 1'b0}, 1'b0, 1'b1, "STATUS");
		pop_and_check(1'b1);
		finish_test("bad accesses", e);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== iq_capture_top.f ====
+incdir+logic
logic/iq_capture_pkg.sv
logic/iq_async_fifo.sv
logic/apb_decode.sv
logic/sample_execute.sv
logic/apb_result.sv
logic/iq_capture_top.sv
tests/iq_capture_tb.sv

// ==== Bender.yml ====
package:
  name: iq_capture

sources:
  - include_dirs:
      - logic
    files:
      - logic/iq_capture_pkg.sv
      - logic/iq_async_fifo.sv
      - logic/apb_decode.sv
      - logic/sample_execute.sv
      - logic/apb_result.sv
      - logic/iq_capture_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - tests/iq_capture_tb.sv
